// ==== hw/bootRom.hex ====
// Boot ROM image, one 16-bit hex word per line
// Line n holds word n, the image repeats every 16 words
3C00
7A12
0F0F
A55A
1234
C0DE
8001
4E71
F00D
2B9C
6D3E
0000
FFFF
9A47
5EED
B10C

// ==== flist.f ====
hw/socPkg.sv
hw/memoryMapper.sv
hw/bootRom.sv
hw/byteRam.sv
hw/uartRegs.sv
hw/interruptCtrl.sv
hw/socTop.sv
verification/socTopTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module socTopTb -f flist.f -o socTopTb &&
./obj_dir/socTopTb || exit 1

// ==== verification/socTopTb.sv ====
`timescale 1ns/1ps

module socTopTb;

	// Bit time and generic wait limit in cycles
	localparam int bitCycles = socPkg::uartDivisor;
	localparam int waitLimit = 400;

	// Register addresses
	localparam logic [15:0] uartDataAddr   = socPkg::uartBase;
	localparam logic [15:0] uartStatusAddr = socPkg::uartBase + 16'd1;
	localparam logic [15:0] intPendAddr    = socPkg::intBase;
	localparam logic [15:0] intMaskAddr    = socPkg::intBase + 16'd1;

	logic          clk;
	logic          arstN;
	socPkg::busReq req;
	logic [15:0]   cpuDout;
	logic [15:0]   cpuDin;
	logic [15:0]   busDin;
	logic          txd;
	logic          rxd;
	logic [2:0]    irqIn;
	logic          irq;

	integer        seed;
	logic [15:0]   romImage [16];
	// Expected RAM contents by address
	logic [15:0]   ramModel [logic [15:0]];
	logic [15:0]   ramAddrs [8];

	socTop socTop_inst (
		.clk     (clk),
		.arstN   (arstN),
		.req     (req),
		.cpuDout (cpuDout),
		.cpuDin  (cpuDin),
		.busDin  (busDin),
		.txd     (txd),
		.rxd     (rxd),
		.irqIn   (irqIn),
		.irq     (irq)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic expectEq(input string testName, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			failRun($sformatf("MISMATCH %s expected %h actual %h", testName, expected, actual));
		end
	endtask

	// Data shows up one cycle after the sampling edge
	task automatic busRead(input logic [15:0] addr, output logic [15:0] data);
		@(posedge clk);
		#1;
		req.addr = addr;
		req.rdN  = 1'b0;
		@(posedge clk);
		#1;
		data     = cpuDin;
		req.rdN  = 1'b1;
	endtask

	// Single-cycle write with wr0 as the high byte lane
	task automatic busWrite(input logic [15:0] addr, input logic [15:0] data,
			input logic wr0, input logic wr1);
		@(posedge clk);
		#1;
		req.addr = addr;
		cpuDout  = data;
		req.wr0N = ~wr0;
		req.wr1N = ~wr1;
		@(posedge clk);
		#1;
		req.wr0N = 1'b1;
		req.wr1N = 1'b1;
	endtask

	task automatic readExpect(input string testName, input logic [15:0] addr,
			input logic [15:0] expected);
		logic [15:0] got;
		busRead(addr, got);
		expectEq(testName, expected, got);
	endtask

	// Poll the status register until it matches
	task automatic waitUartStatus(input string testName, input logic [15:0] want);
		int          tries;
		logic [15:0] st;
		tries = 0;
		busRead(uartStatusAddr, st);
		while (st !== want && tries < waitLimit) begin
			busRead(uartStatusAddr, st);
			tries++;
		end
		assert (st === want) else begin
			failRun($sformatf("%s timed out waiting for UART status %h", testName, want));
		end
	endtask

	// Drive one 8N1 frame on rxd
	task automatic uartSendToRx(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++) begin
			rxd = frame[i];
			repeat (bitCycles) @(posedge clk);
			#1;
		end
	endtask

	// Returns at the middle of the stop bit
	task automatic uartCollectTx(output logic [7:0] data);
		int         cycles;
		logic [9:0] frame;
		cycles = 0;
		while (txd !== 1'b0 && cycles < waitLimit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		assert (txd === 1'b0) else failRun("no start bit appeared on txd");
		// Move to mid-bit
		repeat (bitCycles / 2) @(posedge clk);
		#1;
		frame[0] = txd;
		for (int i = 1; i < 10; i++) begin
			repeat (bitCycles) @(posedge clk);
			#1;
			frame[i] = txd;
		end
		assert (frame[0] === 1'b0 && frame[9] === 1'b1) else begin
			failRun("txd frame has a bad start or stop bit");
		end
		data = frame[8:1];
	endtask

	task automatic romAliasing();
		logic [15:0] addrs [6];
		addrs = '{16'h0000, 16'h0005, 16'h000F, 16'h0013, 16'h0ABC, 16'h1FFF};
		// Index is addr mod 16
		foreach (addrs[i]) begin
			readExpect("rom alias", addrs[i], romImage[addrs[i][3:0]]);
		end
	endtask

	task automatic ramByteLanes();
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] m;
		for (int i = 0; i < 8; i++) begin
			a = socPkg::ramBase + 16'($unsigned($random(seed)) % socPkg::ramWords);
			d = 16'($random(seed));
			ramAddrs[i] = a;
			busWrite(a, d, 1'b1, 1'b1);
			ramModel[a] = d;
		end
		foreach (ramAddrs[i]) readExpect("ram word", ramAddrs[i], ramModel[ramAddrs[i]]);
		// High lane only
		foreach (ramAddrs[i]) begin
			d = 16'($random(seed));
			busWrite(ramAddrs[i], d, 1'b1, 1'b0);
			m = ramModel[ramAddrs[i]];
			m[15:8] = d[15:8];
			ramModel[ramAddrs[i]] = m;
		end
		foreach (ramAddrs[i]) readExpect("ram high lane", ramAddrs[i], ramModel[ramAddrs[i]]);
		// Low lane only
		foreach (ramAddrs[i]) begin
			d = 16'($random(seed));
			busWrite(ramAddrs[i], d, 1'b0, 1'b1);
			m = ramModel[ramAddrs[i]];
			m[7:0] = d[7:0];
			ramModel[ramAddrs[i]] = m;
		end
		foreach (ramAddrs[i]) readExpect("ram low lane", ramAddrs[i], ramModel[ramAddrs[i]]);
	endtask

	task automatic unmappedSpace();
		busDin = 16'($random(seed));
		readExpect("unmapped 8000", 16'h8000, busDin);
		busDin = 16'($random(seed));
		readExpect("unmapped fff8", 16'hFFF8, busDin);
		// 0xFFF8 minus ramBase shares its low 15 bits with word 0x7FF8
		busWrite(16'h7FF8, 16'h1234, 1'b1, 1'b1);
		ramModel[16'h7FF8] = 16'h1234;
		busWrite(16'h8000, 16'hDEAD, 1'b1, 1'b1);
		busWrite(16'hFFF8, 16'hBEEF, 1'b1, 1'b1);
		readExpect("unmapped write", 16'h7FF8, ramModel[16'h7FF8]);
	endtask

	task automatic uartTransmit();
		logic [7:0] b;
		logic [7:0] got;
		b = 8'($random(seed));
		busWrite(uartDataAddr, {8'h00, b}, 1'b1, 1'b1);
		uartCollectTx(got);
		expectEq("uart tx byte", {8'h00, b}, {8'h00, got});
		// Still inside the stop bit
		readExpect("uart tx busy", uartStatusAddr, 16'h0001);
		waitUartStatus("uart tx idle", 16'h0000);
	endtask

	task automatic uartReceiveIrq();
		logic [7:0] b;
		b = 8'($random(seed));
		uartSendToRx(b);
		waitUartStatus("uart rx full", 16'h0002);
		expectEq("uart rx irq masked", 16'h0000, {15'b0, irq});
		readExpect("uart rx pending", intPendAddr, 16'h0001);
		busWrite(intMaskAddr, 16'h0001, 1'b1, 1'b1);
		expectEq("uart rx irq unmasked", 16'h0001, {15'b0, irq});
		readExpect("uart rx data", uartDataAddr, {8'h00, b});
		readExpect("uart rx status clear", uartStatusAddr, 16'h0000);
		// Write one to clear
		busWrite(intPendAddr, 16'h0001, 1'b1, 1'b1);
		expectEq("uart rx irq cleared", 16'h0000, {15'b0, irq});
		readExpect("uart rx pending clear", intPendAddr, 16'h0000);
	endtask

	task automatic externalIrq();
		logic [15:0] bitMask;
		busWrite(intMaskAddr, 16'h0000, 1'b1, 1'b1);
		for (int i = 1; i < 4; i++) begin
			bitMask = 16'd1 << i;
			@(posedge clk);
			#1;
			irqIn[i-1] = 1'b1;
			readExpect($sformatf("ext irq %0d pending", i), intPendAddr, bitMask);
			expectEq($sformatf("ext irq %0d masked", i), 16'h0000, {15'b0, irq});
			busWrite(intMaskAddr, bitMask, 1'b1, 1'b1);
			expectEq($sformatf("ext irq %0d raised", i), 16'h0001, {15'b0, irq});
			busWrite(intPendAddr, bitMask, 1'b1, 1'b1);
			expectEq($sformatf("ext irq %0d cleared", i), 16'h0000, {15'b0, irq});
			// Level still high so no new edge
			repeat (4) @(posedge clk);
			#1;
			readExpect($sformatf("ext irq %0d held", i), intPendAddr, 16'h0000);
			irqIn[i-1] = 1'b0;
			busWrite(intMaskAddr, 16'h0000, 1'b1, 1'b1);
		end
	endtask

	// Overall limit on simulation time
	initial begin
		#2000000;
		failRun("simulation ran past its time limit");
	end

	initial begin
		seed     = 32'hfb74;
		arstN    = 1'b0;
		req.addr = 16'h0000;
		req.rdN  = 1'b1;
		req.wr0N = 1'b1;
		req.wr1N = 1'b1;
		cpuDout  = 16'h0000;
		busDin   = 16'h0000;
		rxd      = 1'b1;
		irqIn    = 3'b000;
		$readmemh("hw/bootRom.hex", romImage);
		repeat (10) @(posedge clk);
		#1;
		arstN = 1'b1;
		expectEq("reset txd", 16'h0001, {15'b0, txd});
		expectEq("reset irq", 16'h0000, {15'b0, irq});
		romAliasing();
		ramByteLanes();
		unmappedSpace();
		uartTransmit();
		uartReceiveIrq();
		externalIrq();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== hw/socTop.sv ====
`timescale 1ns/1ps

module socTop (
	input  logic          clk,
	input  logic          arstN,
	input  socPkg::busReq req,
	input  logic [15:0]   cpuDout,
	output logic [15:0]   cpuDin,
	input  logic [15:0]   busDin,
	output logic          txd,
	input  logic          rxd,
	input  logic [2:0]    irqIn,
	output logic          irq
);

	logic             romEn;
	logic [15:0]      romDin;
	logic [15:0]      ramDin;
	logic [15:0]      uartDin;
	logic [15:0]      intDin;
	logic [15:0]      ramOffset;
	logic             rxFull;
	socPkg::ramCtrl   ramCtl;
	socPkg::devStrobe uartStb;
	socPkg::devStrobe intcStb;

	// Word index within RAM
	assign ramOffset = req.addr - socPkg::ramBase;

	memoryMapper memoryMapper_inst (
		.clk     (clk),
		.arstN   (arstN),
		.req     (req),
		.cpuDin  (cpuDin),
		.busDin  (busDin),
		.romDin  (romDin),
		.ramDin  (ramDin),
		.uartDin (uartDin),
		.intDin  (intDin),
		.romEn   (romEn),
		.ram     (ramCtl),
		.uart    (uartStb),
		.intc    (intcStb)
	);

	// Image aliases on the low four bits
	bootRom bootRom_inst (
		.clk  (clk),
		.en   (romEn),
		.addr (req.addr[3:0]),
		.dout (romDin)
	);

	byteRam byteRam_inst (
		.clk  (clk),
		.ctrl (ramCtl),
		.addr (ramOffset[14:0]),
		.din  (cpuDout),
		.dout (ramDin)
	);

	uartRegs uartRegs_inst (
		.clk    (clk),
		.arstN  (arstN),
		.strobe (uartStb),
		.din    (cpuDout[7:0]),
		.dout   (uartDin),
		.txd    (txd),
		.rxd    (rxd),
		.rxFull (rxFull)
	);

	// Receive full is source 0, pins above it
	interruptCtrl interruptCtrl_inst (
		.clk     (clk),
		.arstN   (arstN),
		.strobe  (intcStb),
		.din     (cpuDout[socPkg::intSources-1:0]),
		.dout    (intDin),
		.sources ({irqIn, rxFull}),
		.irq     (irq)
	);

endmodule

// ==== hw/interruptCtrl.sv ====
`timescale 1ns/1ps

module interruptCtrl (
	input  logic                          clk,
	input  logic                          arstN,
	input  socPkg::devStrobe              strobe,
	input  logic [socPkg::intSources-1:0] din,
	output logic [15:0]                   dout,
	input  logic [socPkg::intSources-1:0] sources,
	output logic                          irq
);

	logic [socPkg::intSources-1:0] pending;
	logic [socPkg::intSources-1:0] mask;
	logic [socPkg::intSources-1:0] srcPrev;
	logic [socPkg::intSources-1:0] rise;
	logic [socPkg::intSources-1:0] clear;

	// Rising edges only, a held level fires once
	assign rise  = sources & ~srcPrev;
	// Write ones to clear
	assign clear = (strobe.wr && strobe.regAddr == socPkg::intRegPending) ? din : '0;
	assign irq   = |(pending & mask);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pending <= '0;
			mask    <= '0;
			srcPrev <= '0;
		end else begin
			srcPrev <= sources;
			// Edge beats a simultaneous clear
			pending <= (pending & ~clear) | rise;
			if (strobe.wr && strobe.regAddr == socPkg::intRegMask) begin
				mask <= din;
			end
		end
	end

	// Registered read data, zero extended
	always_ff @(posedge clk) begin
		if (strobe.rd) begin
			case (strobe.regAddr)
				socPkg::intRegPending: dout <= 16'(pending);
				socPkg::intRegMask:    dout <= 16'(mask);
				default:               dout <= '0;
			endcase
		end
	end

endmodule

// ==== hw/uartRegs.sv ====
`timescale 1ns/1ps

module uartRegs (
	input  logic             clk,
	input  logic             arstN,
	input  socPkg::devStrobe strobe,
	input  logic [7:0]       din,
	output logic [15:0]      dout,
	output logic             txd,
	input  logic             rxd,
	output logic             rxFull
);

	// Transmitter state
	logic             txBusy;
	logic [3:0]       txBitCnt;
	socPkg::uartCount txClkCnt;
	logic [9:0]       txShift;
	logic             txStart;
	logic             txBitEnd;

	// Receiver state
	logic [1:0]       rxSync;
	logic             rxActive;
	logic [3:0]       rxBitCnt;
	socPkg::uartCount rxClkCnt;
	logic [7:0]       rxShift;
	logic [7:0]       rxData;
	logic             rxSample;
	logic             rxDone;
	logic             rxClear;
	logic             rdPrev;

	// Data write while busy is dropped
	assign txStart  = strobe.wr && strobe.regAddr == socPkg::uartRegData && !txBusy;
	assign txBitEnd = txClkCnt == socPkg::uartCount'(socPkg::uartDivisor - 1);
	// Line idles high
	assign txd      = txBusy ? txShift[0] : 1'b1;

	// Bit timing for the frame
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			txBusy   <= 1'b0;
			txBitCnt <= '0;
			txClkCnt <= '0;
		end else if (txStart) begin
			txBusy   <= 1'b1;
			txBitCnt <= '0;
			txClkCnt <= '0;
		end else if (txBusy) begin
			if (txBitEnd) begin
				txClkCnt <= '0;
				// Stop bit was the tenth
				if (txBitCnt == 4'd9) begin
					txBusy <= 1'b0;
				end else begin
					txBitCnt <= txBitCnt + 1'b1;
				end
			end else begin
				txClkCnt <= txClkCnt + 1'b1;
			end
		end
	end

	// Frame shifter, stop, data LSB first, start
	always_ff @(posedge clk) begin
		if (txStart) begin
			txShift <= {1'b1, din, 1'b0};
		end else if (txBusy && txBitEnd) begin
			txShift <= {1'b1, txShift[9:1]};
		end
	end

	// Mid-bit sample point
	assign rxSample = rxActive && rxClkCnt == socPkg::uartCount'(socPkg::uartDivisor / 2 - 1);
	assign rxDone   = rxSample && rxBitCnt == 4'd9 && rxSync[1];
	// First cycle of a data register read
	assign rxClear  = strobe.rd && !rdPrev && strobe.regAddr == socPkg::uartRegData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rxSync   <= 2'b11;
			rxActive <= 1'b0;
			rxBitCnt <= '0;
			rxClkCnt <= '0;
			rxFull   <= 1'b0;
			rdPrev   <= 1'b0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rdPrev <= strobe.rd;
			if (rxClear) begin
				rxFull <= 1'b0;
			end
			if (!rxActive) begin
				rxClkCnt <= '0;
				rxBitCnt <= '0;
				// Falling edge starts a frame
				if (!rxSync[1]) begin
					rxActive <= 1'b1;
				end
			end else begin
				if (rxClkCnt == socPkg::uartCount'(socPkg::uartDivisor - 1)) begin
					rxClkCnt <= '0;
				end else begin
					rxClkCnt <= rxClkCnt + 1'b1;
				end
				if (rxSample) begin
					rxBitCnt <= rxBitCnt + 1'b1;
					if (rxBitCnt == 4'd0 && rxSync[1]) begin
						// Glitch, not a real start bit
						rxActive <= 1'b0;
					end else if (rxBitCnt == 4'd9) begin
						rxActive <= 1'b0;
						// New byte wins over a clear
						if (rxSync[1]) begin
							rxFull <= 1'b1;
						end
					end
				end
			end
		end
	end

	// Receive shifter and holding register
	always_ff @(posedge clk) begin
		if (rxSample && rxBitCnt >= 4'd1 && rxBitCnt <= 4'd8) begin
			rxShift <= {rxSync[1], rxShift[7:1]};
		end
		if (rxDone) begin
			rxData <= rxShift;
		end
	end

	// Registered read data
	always_ff @(posedge clk) begin
		if (strobe.rd) begin
			case (strobe.regAddr)
				socPkg::uartRegData:   dout <= {8'h00, rxData};
				socPkg::uartRegStatus: dout <= {14'b0, rxFull, txBusy};
				default:               dout <= '0;
			endcase
		end
	end

endmodule

// ==== hw/byteRam.sv ====
`timescale 1ns/1ps

module byteRam (
	input  logic           clk,
	input  socPkg::ramCtrl ctrl,
	input  logic [14:0]    addr,
	input  logic [15:0]    din,
	output logic [15:0]    dout
);

	logic [15:0] mem [socPkg::ramWords];

	// Per-lane writes
	always_ff @(posedge clk) begin
		if (ctrl.en && ctrl.wr) begin
			// Low byte lane
			if (ctrl.be0) begin
				mem[addr][7:0] <= din[7:0];
			end
			// High byte lane
			if (ctrl.be1) begin
				mem[addr][15:8] <= din[15:8];
			end
		end
	end

	// Synchronous read port
	always_ff @(posedge clk) begin
		if (ctrl.en && !ctrl.wr) begin
			dout <= mem[addr];
		end
	end

endmodule

// ==== hw/bootRom.sv ====
`timescale 1ns/1ps

module bootRom (
	input  logic        clk,
	input  logic        en,
	input  logic [3:0]  addr,
	output logic [15:0] dout
);

	// Image storage
	logic [15:0] mem [socPkg::romWords];

	// Image is loaded from the hex file at elaboration
	initial begin
		$readmemh("hw/bootRom.hex", mem);
	end

	// Registered read, only when enabled
	always_ff @(posedge clk) begin
		if (en) begin
			dout <= mem[addr];
		end
	end

endmodule

// ==== hw/memoryMapper.sv ====
`timescale 1ns/1ps

module memoryMapper (
	input  logic             clk,
	input  logic             arstN,
	input  socPkg::busReq    req,
	output logic [15:0]      cpuDin,
	input  logic [15:0]      busDin,
	input  logic [15:0]      romDin,
	input  logic [15:0]      ramDin,
	input  logic [15:0]      uartDin,
	input  logic [15:0]      intDin,
	output logic             romEn,
	output socPkg::ramCtrl   ram,
	output socPkg::devStrobe uart,
	output socPkg::devStrobe intc
);

	logic             read;
	logic             write;
	logic [15:0]      romOffset;
	logic [15:0]      ramOffset;
	socPkg::devSelect hit;
	socPkg::devSelect readSel;

	assign read  = ~req.rdN;
	// Either byte lane counts as a write
	assign write = ~req.wr0N | ~req.wr1N;

	// Offsets into the memory regions
	assign romOffset = req.addr - socPkg::romBase;
	assign ramOffset = req.addr - socPkg::ramBase;

	// Address decode
	assign hit.rom  = romOffset <= (socPkg::romTop - socPkg::romBase);
	assign hit.ram  = ramOffset <= (socPkg::ramTop - socPkg::ramBase);
	assign hit.uart = req.addr[15:2] == socPkg::uartBase[15:2];
	assign hit.intc = req.addr[15:2] == socPkg::intBase[15:2];

	// ROM only clocks out data on a read
	assign romEn = hit.rom & read;

	// RAM enables and byte lanes
	always_comb begin
		ram = '0;
		if (hit.ram) begin
			ram.en = read | write;
			if (read) begin
				// Reads fetch the whole word
				ram.be0 = 1'b1;
				ram.be1 = 1'b1;
			end else if (write) begin
				ram.wr  = 1'b1;
				// Lane numbering is reversed on this processor
				ram.be1 = ~req.wr0N;
				ram.be0 = ~req.wr1N;
			end
		end
	end

	// Register device strobes
	always_comb begin
		uart.rd      = hit.uart & read;
		uart.wr      = hit.uart & write;
		uart.regAddr = req.addr[1:0];
		intc.rd      = hit.intc & read;
		intc.wr      = hit.intc & write;
		intc.regAddr = req.addr[1:0];
	end

	// Remember the source of the read in flight
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			readSel <= '0;
		end else if (read) begin
			readSel <= hit;
		end
	end

	// All devices answer one cycle late, so mux on the stored select
	always_comb begin
		if (readSel.ram) begin
			cpuDin = ramDin;
		end else if (readSel.rom) begin
			cpuDin = romDin;
		end else if (readSel.uart) begin
			cpuDin = uartDin;
		end else if (readSel.intc) begin
			cpuDin = intDin;
		end else begin
			// Nothing on chip, pass the external bus
			cpuDin = busDin;
		end
	end

endmodule

// ==== hw/socPkg.sv ====
package socPkg;

	// ROM region, 16-word image repeats across it
	localparam logic [15:0] romBase = 16'h0000;
	localparam logic [15:0] romTop  = 16'h1FFF;

	// Byte-writable RAM region
	localparam logic [15:0] ramBase = 16'h2000;
	localparam logic [15:0] ramTop  = 16'h7FFF;

	// Register blocks, four words each
	localparam logic [15:0] uartBase = 16'hFFF0;
	localparam logic [15:0] intBase  = 16'hFFF4;

	// Memory sizes in words
	localparam int romWords = 16;
	localparam int ramWords = 24576;

	// Clocks per serial bit
	localparam int uartDivisor = 16;
	localparam int uartCountW  = $clog2(uartDivisor);

	// Counter type for the bit timers
	typedef logic [uartCountW-1:0] uartCount;

	// UART register offsets
	localparam logic [1:0] uartRegData   = 2'd0;
	localparam logic [1:0] uartRegStatus = 2'd1;

	// Interrupt controller register offsets
	localparam logic [1:0] intRegPending = 2'd0;
	localparam logic [1:0] intRegMask    = 2'd1;

	// Source 0 is UART receive full, 1..3 are pins
	localparam int intSources = 4;

	// Processor request, strobes active low
	typedef struct packed {
		logic [15:0] addr;
		logic        rdN;
		logic        wr0N;
		logic        wr1N;
	} busReq;

	// Strobes for a register device
	typedef struct packed {
		logic       rd;
		logic       wr;
		logic [1:0] regAddr;
	} devStrobe;

	// RAM controls, be1 is bits 15:8
	typedef struct packed {
		logic en;
		logic wr;
		logic be0;
		logic be1;
	} ramCtrl;

	// One-hot device hit
	typedef struct packed {
		logic ram;
		logic rom;
		logic uart;
		logic intc;
	} devSelect;

endpackage
